/* hw/dcache_config.svh */
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// cache geometry for the 32-bit data cache
// address layout, msb first: tag | index | block offset | byte

// data word and bus address width
`define DCACHE_WORD_W 32

// sets in each of the two ways
`define DCACHE_SETS 8
`define DCACHE_IDX_W 3 // log2 of the set count

// word width minus index, block offset and byte bits
`define DCACHE_TAG_W 26

// words per block
`define DCACHE_BLK_WORDS 2

`endif

/* hw/dcache_pkg.sv */
`include "dcache_config.svh"

package dcache_pkg;

	// one data or address word
	typedef logic [`DCACHE_WORD_W-1:0] word_t;

	// field view of an address, msb first
	typedef struct packed {
		logic [`DCACHE_TAG_W-1:0] tag;
		logic [`DCACHE_IDX_W-1:0] idx; // set select
		logic                     blkoff; // word within the block
		logic [1:0]               byteoff; // zero for word accesses
	} dcache_addr_fields_t;

	// raw word on the buses, fields for lookup and address rebuild
	typedef union packed {
		word_t               raw;
		dcache_addr_fields_t fields;
	} dcache_addr_t;

	// one row of one way, 92 bits
	typedef struct packed {
		logic [`DCACHE_TAG_W-1:0]      tag;
		word_t [`DCACHE_BLK_WORDS-1:0] block; // block[0] is the lower word
		logic                          valid;
		logic                          dirty; // only ever set together with valid
	} dcache_frame_t;

	// controller states
	typedef enum logic [3:0] {
		IDLE,
		FETCH1, FETCH2, // fill word 0, then word 1
		WB1, WB2, // victim writeback, word 0 then word 1
		FLUSH1, FLUSH2, FLUSH3, FLUSH4, // way0 w0, way0 w1, way1 w0, way1 w1
		DONE // table cleared, flushed held high
	} dcache_state_t;

endpackage

/* hw/dcache_array_if.sv */
`timescale 1ns/1ps
`include "dcache_config.svh"

interface dcache_array_if import dcache_pkg::*; ();

	// lookup results from the table
	logic                      hit; // request matched a valid row
	logic                      hit_way;
	logic                      victim_way; // lru way of the request set
	dcache_frame_t             victim_frame;
	dcache_frame_t [1:0]       flush_frames; // both ways at flush_idx

	// write port, always at the request index
	logic                      wen;
	logic                      clear; // drop every valid and dirty bit
	logic                      wr_way;
	logic                      wr_word;
	logic [`DCACHE_TAG_W-1:0]  wr_tag;
	word_t                     wr_data;
	logic                      wr_valid;
	logic                      wr_dirty;

	logic [`DCACHE_IDX_W-1:0]  flush_idx; // set being walked by the flush

	modport array (
		output hit, hit_way, victim_way, victim_frame, flush_frames,
		input  wen, clear, wr_way, wr_word, wr_tag, wr_data, wr_valid, wr_dirty, flush_idx
	);

	modport ctrl (
		input  hit, hit_way, victim_way, victim_frame, flush_frames,
		output wen, clear, wr_way, wr_word, wr_tag, wr_data, wr_valid, wr_dirty, flush_idx
	);

endinterface

/* hw/dcache_array.sv */
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_array import dcache_pkg::*; (
	input  logic          CLK,
	input  logic          nRST,
	input  logic          dmem_ren,
	input  logic          dmem_wen,
	input  dcache_addr_t  dmem_addr,
	output word_t         dmem_load,
	dcache_array_if.array aif
);

	// storage, tag and data hold no reset state
	logic [`DCACHE_TAG_W-1:0]      tag_mem [2][`DCACHE_SETS];
	word_t [`DCACHE_BLK_WORDS-1:0] data_mem [2][`DCACHE_SETS];
	logic [1:0][`DCACHE_SETS-1:0]  valid_q; // [way][set]
	logic [1:0][`DCACHE_SETS-1:0]  dirty_q;
	logic [`DCACHE_SETS-1:0]       lru_q; // 1 bit per set, names the way to evict

	logic [`DCACHE_IDX_W-1:0]      idx;
	logic                          req; // a processor access is pending
	logic [1:0]                    way_hit;
	dcache_frame_t                 req_frame [2]; // both ways at the request index

	assign idx = dmem_addr.fields.idx;
	assign req = dmem_ren | dmem_wen;

	// assemble rows for the request set and for the flush set
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			req_frame[w].tag   = tag_mem[w][idx];
			req_frame[w].block = data_mem[w][idx];
			req_frame[w].valid = valid_q[w][idx];
			req_frame[w].dirty = dirty_q[w][idx];

			aif.flush_frames[w].tag   = tag_mem[w][aif.flush_idx];
			aif.flush_frames[w].block = data_mem[w][aif.flush_idx];
			aif.flush_frames[w].valid = valid_q[w][aif.flush_idx];
			aif.flush_frames[w].dirty = dirty_q[w][aif.flush_idx];

			// tag compare, qualified by valid and by a live request
			way_hit[w] = req && req_frame[w].valid && (req_frame[w].tag == dmem_addr.fields.tag);
		end
	end

	assign aif.hit      = |way_hit;
	assign aif.hit_way  = way_hit[1]; // at most one way can match
	assign aif.victim_way   = lru_q[idx];
	assign aif.victim_frame = req_frame[lru_q[idx]];

	// read data straight out of the hit row, same cycle as the request
	assign dmem_load = req_frame[aif.hit_way].block[dmem_addr.fields.blkoff];

	// valid, dirty and lru bits
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid_q <= '0;
			dirty_q <= '0;
			lru_q   <= '0;
		end else if (aif.clear) begin // end of flush, empty the table
			valid_q <= '0;
			dirty_q <= '0;
			lru_q   <= '0;
		end else begin
			if (aif.hit) begin
				lru_q[idx] <= ~aif.hit_way; // other way becomes the victim
			end
			if (aif.wen) begin
				valid_q[aif.wr_way][idx] <= aif.wr_valid;
				dirty_q[aif.wr_way][idx] <= aif.wr_dirty;
			end
		end
	end

	// tag and one word per write, way picked by the controller
	always_ff @(posedge CLK) begin
		if (aif.wen) begin
			tag_mem[aif.wr_way][idx]               <= aif.wr_tag;
			data_mem[aif.wr_way][idx][aif.wr_word] <= aif.wr_data;
		end
	end

endmodule

/* hw/dcache_ctrl.sv */
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_ctrl import dcache_pkg::*; (
	input  logic         CLK,
	input  logic         nRST,
	input  logic         dmem_ren,
	input  logic         dmem_wen,
	input  dcache_addr_t dmem_addr,
	input  word_t        dmem_store,
	input  logic         halt,
	output logic         flushed,
	output logic         mem_ren,
	output logic         mem_wen,
	output dcache_addr_t mem_addr,
	output word_t        mem_store,
	input  word_t        mem_load,
	input  logic         mem_wait,
	dcache_array_if.ctrl aif
);

	dcache_state_t            state;
	dcache_state_t            next_state;
	logic [`DCACHE_IDX_W-1:0] flush_idx; // set walked by FLUSH1..FLUSH4
	logic                     flush_step; // move to the next set
	logic                     flush_last;
	logic                     miss;
	logic                     victim_dirty; // victim needs a writeback before the fill
	logic                     word_sel; // second word of a two-transfer pair
	logic                     fl_way;
	dcache_frame_t            fl_frame;
	logic                     fl_dirty;

	assign miss         = (dmem_ren | dmem_wen) & ~aif.hit;
	assign victim_dirty = aif.victim_frame.valid & aif.victim_frame.dirty;
	assign word_sel     = state inside {WB2, FETCH2, FLUSH2, FLUSH4};

	// flush slot decode
	assign fl_way     = state inside {FLUSH3, FLUSH4};
	assign fl_frame   = aif.flush_frames[fl_way];
	assign fl_dirty   = fl_frame.valid & fl_frame.dirty; // clean slots send nothing
	assign flush_last = (flush_idx == `DCACHE_IDX_W'(`DCACHE_SETS - 1));

	assign flushed       = (state == DONE); // DONE only leaves on reset
	assign aif.flush_idx = flush_idx;

	// next state, every transfer state waits on mem_wait
	always_comb begin
		next_state = state;
		flush_step = 1'b0;
		case (state)
			IDLE: begin
				if (halt) begin
					next_state = FLUSH1; // halt wins over a pending access
				end else if (miss) begin
					next_state = victim_dirty ? WB1 : FETCH1;
				end
			end
			WB1: begin
				if (!mem_wait) begin
					next_state = WB2;
				end
			end
			WB2: begin
				if (!mem_wait) begin
					next_state = FETCH1;
				end
			end
			FETCH1: begin
				if (!mem_wait) begin
					next_state = FETCH2;
				end
			end
			FETCH2: begin
				if (!mem_wait) begin
					next_state = IDLE; // block now valid, dhit rises here
				end
			end
			FLUSH1: begin
				if (!fl_dirty || !mem_wait) begin
					next_state = FLUSH2;
				end
			end
			FLUSH2: begin
				if (!fl_dirty || !mem_wait) begin
					next_state = FLUSH3;
				end
			end
			FLUSH3: begin
				if (!fl_dirty || !mem_wait) begin
					next_state = FLUSH4;
				end
			end
			FLUSH4: begin
				if (!fl_dirty || !mem_wait) begin
					flush_step = 1'b1;
					next_state = flush_last ? DONE : FLUSH1;
				end
			end
			DONE: next_state = DONE;
			default: next_state = IDLE;
		endcase
	end

	// memory strobes and table writes
	always_comb begin
		mem_ren   = 1'b0;
		mem_wen   = 1'b0;
		mem_addr  = dmem_addr; // request index unless a state overrides it
		mem_store = '0;

		aif.wen      = 1'b0;
		aif.clear    = 1'b0;
		aif.wr_way   = aif.hit_way;
		aif.wr_word  = dmem_addr.fields.blkoff;
		aif.wr_tag   = dmem_addr.fields.tag;
		aif.wr_data  = dmem_store;
		aif.wr_valid = 1'b1;
		aif.wr_dirty = 1'b1;

		case (state)
			IDLE: begin
				aif.wen = !halt && aif.hit && dmem_wen; // write hit, row goes dirty
			end
			WB1, WB2: begin
				mem_wen = 1'b1;
				mem_addr.fields.tag     = aif.victim_frame.tag; // rebuild victim address
				mem_addr.fields.blkoff  = word_sel;
				mem_addr.fields.byteoff = 2'b00;
				mem_store = aif.victim_frame.block[word_sel];
			end
			FETCH1, FETCH2: begin
				mem_ren = 1'b1;
				mem_addr.fields.blkoff  = word_sel;
				mem_addr.fields.byteoff = 2'b00;
				aif.wen      = !mem_wait; // write only when the word lands
				aif.wr_way   = aif.victim_way;
				aif.wr_word  = word_sel;
				aif.wr_data  = mem_load;
				aif.wr_valid = word_sel; // valid once word 1 is in
				aif.wr_dirty = 1'b0;
			end
			FLUSH1, FLUSH2, FLUSH3, FLUSH4: begin
				mem_wen = fl_dirty;
				mem_addr.fields.tag     = fl_frame.tag;
				mem_addr.fields.idx     = flush_idx;
				mem_addr.fields.blkoff  = word_sel;
				mem_addr.fields.byteoff = 2'b00;
				mem_store = fl_frame.block[word_sel];
			end
			DONE: begin
				aif.clear = 1'b1;
			end
			default: begin
				aif.wen = 1'b0;
			end
		endcase
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state     <= IDLE;
			flush_idx <= '0;
		end else begin
			state <= next_state;
			if (flush_step) begin
				flush_idx <= flush_idx + 1'b1; // wraps to 0 after the last set
			end
		end
	end

endmodule

/* hw/dcache.sv */
`timescale 1ns/1ps

module dcache import dcache_pkg::*; (
	input  logic  CLK,
	input  logic  nRST,
	// processor side
	input  logic  dmem_ren,
	input  logic  dmem_wen,
	input  word_t dmem_addr,
	input  word_t dmem_store,
	input  logic  halt,
	output logic  dhit,
	output word_t dmem_load,
	output logic  flushed,
	// memory side
	output logic  mem_ren,
	output logic  mem_wen,
	output word_t mem_addr,
	output word_t mem_store,
	input  word_t mem_load,
	input  logic  mem_wait
);

	dcache_addr_t req_addr; // processor address split into fields
	dcache_addr_t bus_addr; // address built by the controller

	dcache_array_if aif ();

	assign req_addr.raw = dmem_addr;
	assign mem_addr     = bus_addr.raw;
	assign dhit         = aif.hit; // combinational, same cycle as the request

	dcache_array i_array (
		.CLK       (CLK),
		.nRST      (nRST),
		.dmem_ren  (dmem_ren),
		.dmem_wen  (dmem_wen),
		.dmem_addr (req_addr),
		.dmem_load (dmem_load),
		.aif       (aif.array)
	);

	dcache_ctrl i_ctrl (
		.CLK        (CLK),
		.nRST       (nRST),
		.dmem_ren   (dmem_ren),
		.dmem_wen   (dmem_wen),
		.dmem_addr  (req_addr),
		.dmem_store (dmem_store),
		.halt       (halt),
		.flushed    (flushed),
		.mem_ren    (mem_ren),
		.mem_wen    (mem_wen),
		.mem_addr   (bus_addr),
		.mem_store  (mem_store),
		.mem_load   (mem_load),
		.mem_wait   (mem_wait),
		.aif        (aif.ctrl)
	);

endmodule

/* tb/dcache_asserts.sv */
`timescale 1ns/1ps

module dcache_asserts import dcache_pkg::*; (
	input logic         CLK,
	input logic         nRST,
	input logic         mem_ren,
	input logic         mem_wen,
	input dcache_addr_t mem_addr,
	input word_t        mem_store,
	input logic         mem_wait,
	input logic         flushed
);

	logic strobe; // any memory command this cycle
	int   fail_count = 0; // failed checks so far

	assign strobe = mem_ren | mem_wen;

	// one command at a time on the memory bus
	one_strobe: assert property (@(posedge CLK) disable iff (!nRST) !(mem_ren && mem_wen))
		else begin
			$error("mem_ren and mem_wen are high together");
			fail_count++;
		end

	// bus goes quiet once the flush has finished
	quiet_after_flush: assert property (@(posedge CLK) disable iff (!nRST) flushed |-> !strobe)
		else begin
			$error("memory strobe high while flushed is set");
			fail_count++;
		end

	// a stalled transfer keeps strobe, address and data
	held_on_wait: assert property (@(posedge CLK) disable iff (!nRST)
		strobe && mem_wait |=> $stable(mem_ren) && $stable(mem_wen)
			&& $stable(mem_addr) && $stable(mem_store))
		else begin
			$error("memory command changed while mem_wait was high");
			fail_count++;
		end

endmodule

bind dcache_ctrl dcache_asserts i_asserts (
	.CLK       (CLK),
	.nRST      (nRST),
	.mem_ren   (mem_ren),
	.mem_wen   (mem_wen),
	.mem_addr  (mem_addr),
	.mem_store (mem_store),
	.mem_wait  (mem_wait),
	.flushed   (flushed)
);

/* tb/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb import dcache_pkg::*; ();

	localparam word_t FILL_KEY = 32'ha5a5_0000; // unwritten memory reads address xor this

	logic  CLK;
	logic  nRST;
	logic  dmem_ren;
	logic  dmem_wen;
	logic  halt;
	word_t dmem_addr;
	word_t dmem_store;
	logic  dhit;
	word_t dmem_load;
	logic  flushed;
	logic  mem_ren;
	logic  mem_wen;
	word_t mem_addr;
	word_t mem_store;
	word_t mem_load;
	logic  mem_wait;

	word_t  mem_model [word_t]; // words the cache has written back
	word_t  shadow [word_t]; // last processor store per address
	int     write_count = 0; // word writes seen by the memory model
	int     mismatches = 0;
	int     failures = 0;
	int     cycle_limit = 0;
	integer seed = 82914;

	logic [7:0] op_q [$]; // R, W or H
	word_t      addr_q [$];
	word_t      data_q [$];
	word_t      exp_q [$]; // read data, or running write count for W and H

	dcache i_dcache (.*);

	function automatic word_t model_read(input word_t a);
		return mem_model.exists(a) ? mem_model[a] : a ^ FILL_KEY;
	endfunction

	task automatic report_mismatch(input string name, input word_t got, input word_t exp);
		$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
		mismatches++;
	endtask

	task automatic show_counts();
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
	endtask

	// checks happen at the falling edge, inputs move at the rising edge
	task automatic wait_dhit();
		@(negedge CLK);
		while (!dhit) @(negedge CLK);
	endtask

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// memory model, 0 to 2 wait cycles per word transfer
	initial begin
		int wait_left;
		bit in_xfer; // a transfer is under way
		mem_wait  = 1'b0;
		mem_load  = '0;
		wait_left = 0;
		in_xfer   = 1'b0;
		forever begin
			@(negedge CLK);
			if ((mem_ren || mem_wen) && !mem_wait) begin // completes at the next edge
				if (mem_wen) begin
					mem_model[mem_addr] = mem_store;
					write_count++;
				end
				in_xfer = 1'b0;
			end else if (mem_ren || mem_wen) begin
				wait_left--;
			end
			@(posedge CLK);
			#2;
			if (mem_ren || mem_wen) begin
				if (!in_xfer) begin
					wait_left = {$random(seed)} % 3;
					in_xfer   = 1'b1;
				end
				mem_wait = (wait_left != 0);
				mem_load = model_read(mem_addr); // valid once wait drops
			end else begin
				mem_wait = 1'b0;
				in_xfer  = 1'b0;
			end
		end
	end

	// watchdog, limit set from the stim length
	initial begin
		int cycles;
		cycles = 0;
		wait (cycle_limit > 0);
		while (cycles < cycle_limit) begin
			@(posedge CLK);
			cycles++;
		end
		$display("ERROR: timeout after %0d cycles, the cache stopped answering", cycles);
		show_counts();
		$display("Verification failed");
		$finish;
	end

	initial begin
		int         fd;
		string      line;
		logic [7:0] op;
		word_t      a;
		word_t      d;
		word_t      e;
		nRST       = 1'b0;
		dmem_ren   = 1'b0;
		dmem_wen   = 1'b0;
		halt       = 1'b0;
		dmem_addr  = '0;
		dmem_store = '0;

		fd = $fopen("tb/dcache_stim.txt", "r");
		if (fd == 0) begin
			$display("ERROR: cannot open tb/dcache_stim.txt");
			failures++;
		end else begin
			while (!$feof(fd)) begin
				if ($fgets(line, fd) > 0 && $sscanf(line, "%c %h %h %h", op, a, d, e) == 4
					&& op inside {"R", "W", "H"}) begin // comment lines fall out here
					op_q.push_back(op);
					addr_q.push_back(a);
					data_q.push_back(d);
					exp_q.push_back(e);
				end
			end
			$fclose(fd);
		end
		cycle_limit = 40 * op_q.size() + 400;

		repeat (8) @(posedge CLK);
		#2;
		nRST = 1'b1;
		@(negedge CLK);
		if (mem_ren || mem_wen || flushed || dhit) begin
			$display("ERROR at %0t: cache outputs not idle after reset", $time);
			failures++;
		end

		foreach (op_q[i]) begin
			@(posedge CLK); // retires the previous request
			#2;
			dmem_ren   = (op_q[i] == "R");
			dmem_wen   = (op_q[i] == "W");
			halt       = (op_q[i] == "H");
			dmem_addr  = addr_q[i];
			dmem_store = data_q[i];
			if (op_q[i] == "H") begin
				@(negedge CLK);
				while (!flushed) @(negedge CLK);
				if (write_count != exp_q[i]) begin
					report_mismatch("mem write count", write_count, exp_q[i]);
				end
				repeat (5) begin // flushed must hold
					@(negedge CLK);
					if (!flushed) begin
						$display("ERROR at %0t: flushed dropped after the flush", $time);
						failures++;
					end
				end
				foreach (shadow[s]) begin // every stored word reached memory
					if (model_read(s) !== shadow[s]) begin
						report_mismatch($sformatf("memory[%h]", s), model_read(s), shadow[s]);
					end
				end
			end else begin
				wait_dhit();
				if (op_q[i] == "R" && dmem_load !== exp_q[i]) begin
					report_mismatch("dmem_load", dmem_load, exp_q[i]);
				end
				if (op_q[i] == "W" && write_count != exp_q[i]) begin // no write-through
					report_mismatch("mem write count", write_count, exp_q[i]);
				end
				if (op_q[i] == "W") begin
					shadow[addr_q[i]] = data_q[i];
				end
			end
		end

		// bus checks bound into the controller
		if (i_dcache.i_ctrl.i_asserts.fail_count != 0) begin
			$display("ERROR: %0d memory bus assertions failed",
				i_dcache.i_ctrl.i_asserts.fail_count);
			failures += i_dcache.i_ctrl.i_asserts.fail_count;
		end

		show_counts();
		if (mismatches + failures == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

/* src.f */
+incdir+hw
hw/dcache_pkg.sv
hw/dcache_array_if.sv
hw/dcache_array.sv
hw/dcache_ctrl.sv
hw/dcache.sv
tb/dcache_asserts.sv
tb/dcache_tb.sv

/* Makefile */
# Verilator build and run for the data cache testbench
# any variable can be set on the command line, e.g. make LOG=run1.log

VERILATOR  ?= verilator
TOP        ?= dcache_tb
RTL_TOP    ?= dcache
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the result, not the exit status of the simulator
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/dcache_stim.txt */
# op addr data expect, all hex, memory preload is addr xor a5a50000
# R expects read data, W and H expect the running count of memory word writes
R 00000108 00000000 a5a50108
R 00000108 00000000 a5a50108
R 0000010c 00000000 a5a5010c
W 0000010c 11112222 00000000
R 0000010c 00000000 11112222
R 00000148 00000000 a5a50148
R 00000108 00000000 a5a50108
R 00000188 00000000 a5a50188
R 0000010c 00000000 11112222
W 0000018c 33334444 00000000
R 00000148 00000000 a5a50148
W 0000014c 55556666 00000002
R 00000108 00000000 a5a50108
R 0000010c 00000000 11112222
R 0000018c 00000000 33334444
W 00000000 77778888 00000006
W 00000020 9999aaaa 00000006
R 00000024 00000000 a5a50024
R 00000000 00000000 77778888
R 00000004 00000000 a5a50004
H 00000000 00000000 0000000a
